/* source/lc4_pkg.sv */
// shared lc4 types, opcodes and constants; every rtl file imports what it needs from here
package lc4_pkg;

    typedef logic [15:0] word_t;     // data, instruction or address
    typedef logic [2:0]  reg_sel_t;
    typedef logic [2:0]  nzp_t;      // {n, z, p}
    typedef logic [3:0]  opcode_t;
    typedef logic [1:0]  fwd_t;      // operand source in execute

    localparam opcode_t OP_BR      = 4'd0;
    localparam opcode_t OP_ARITH   = 4'd1;
    localparam opcode_t OP_LOGIC   = 4'd5;
    localparam opcode_t OP_LDR     = 4'd6;
    localparam opcode_t OP_STR     = 4'd7;
    localparam opcode_t OP_CONST   = 4'd9;
    localparam opcode_t OP_JMP     = 4'd12;
    localparam opcode_t OP_HICONST = 4'd13;

    localparam word_t PC_RESET = 16'h8200;
    localparam int    NUM_REGS = 8;

    localparam nzp_t NZP_NEG  = 3'b100;
    localparam nzp_t NZP_ZERO = 3'b010;
    localparam nzp_t NZP_POS  = 3'b001;

    localparam fwd_t FWD_REG = 2'd0;  // value read in decode
    localparam fwd_t FWD_M   = 2'd1;  // mx path
    localparam fwd_t FWD_W   = 2'd2;  // wx path

    // condition bits of a written value
    function automatic nzp_t nzp_of(input word_t value);
        return value[15] ? NZP_NEG : (value == '0) ? NZP_ZERO : NZP_POS;
    endfunction

endpackage

/* source/lc4_decoder.sv */
// combinational lc4 decode of the instruction in d into register selects and control levels
module lc4_decoder (
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::reg_sel_t o_rs_sel,
    output lc4_pkg::reg_sel_t o_rt_sel,
    output lc4_pkg::reg_sel_t o_rd_sel,
    output logic              o_rs_re,
    output logic              o_rt_re,
    output logic              o_reg_we,
    output logic              o_nzp_we,
    output logic              o_is_load,
    output logic              o_is_store,
    output logic              o_is_branch,
    output logic              o_is_control
);
    import lc4_pkg::*;

    opcode_t op;

    assign op       = i_insn[15:12];
    assign o_rd_sel = i_insn[11:9];
    assign o_rs_sel = (op == OP_HICONST) ? i_insn[11:9] : i_insn[8:6];  // hiconst keeps rd low byte
    assign o_rt_sel = (op == OP_STR) ? i_insn[11:9] : i_insn[2:0];     // store data register

    always_comb begin
        o_rs_re      = 1'b0;
        o_rt_re      = 1'b0;
        o_reg_we     = 1'b0;
        o_nzp_we     = 1'b0;
        o_is_load    = 1'b0;
        o_is_store   = 1'b0;
        o_is_branch  = 1'b0;
        o_is_control = 1'b0;
        case (op)
            OP_BR: o_is_branch = |i_insn[11:9];  // nzp of 000 is a nop
            OP_ARITH: begin
                // only add, sub and add immediate; mul and div fall out as no-ops
                if (i_insn[5] || !i_insn[3]) begin
                    o_rs_re  = 1'b1;
                    o_rt_re  = !i_insn[5];
                    o_reg_we = 1'b1;
                    o_nzp_we = 1'b1;
                end
            end
            OP_LOGIC: begin
                o_rs_re  = 1'b1;
                o_rt_re  = !i_insn[5] && (i_insn[4:3] != 2'b01);  // not reads rs only
                o_reg_we = 1'b1;
                o_nzp_we = 1'b1;
            end
            OP_LDR: begin
                o_rs_re   = 1'b1;
                o_reg_we  = 1'b1;
                o_nzp_we  = 1'b1;
                o_is_load = 1'b1;
            end
            OP_STR: begin
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
            end
            OP_CONST, OP_HICONST: begin
                o_rs_re  = (op == OP_HICONST);
                o_reg_we = 1'b1;
                o_nzp_we = 1'b1;
            end
            OP_JMP: begin
                o_rs_re      = !i_insn[11];  // jmpr
                o_is_control = 1'b1;
            end
            default: o_is_control = 1'b0;  // unsupported opcodes write nothing
        endcase
    end

endmodule

/* source/lc4_alu.sv */
// lc4 execute datapath: arithmetic, logic, constants, memory addresses and jump targets
module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_pc,
    input  lc4_pkg::word_t i_rs_data,
    input  lc4_pkg::word_t i_rt_data,
    output lc4_pkg::word_t o_result
);
    import lc4_pkg::*;

    word_t imm5, imm6, imm9, imm11, pc_inc;

    assign imm5   = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6   = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9   = {{7{i_insn[8]}}, i_insn[8:0]};
    assign imm11  = {{5{i_insn[10]}}, i_insn[10:0]};
    assign pc_inc = i_pc + 16'd1;

    always_comb begin
        case (opcode_t'(i_insn[15:12]))
            OP_BR:    o_result = pc_inc + imm9;
            OP_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_data + imm5;
                end else begin
                    o_result = i_insn[4] ? i_rs_data - i_rt_data : i_rs_data + i_rt_data;
                end
            end
            OP_LOGIC: begin
                case (i_insn[5:3])
                    3'b000:  o_result = i_rs_data & i_rt_data;
                    3'b001:  o_result = ~i_rs_data;
                    3'b010:  o_result = i_rs_data | i_rt_data;
                    3'b011:  o_result = i_rs_data ^ i_rt_data;
                    default: o_result = i_rs_data & imm5;
                endcase
            end
            OP_LDR, OP_STR: o_result = i_rs_data + imm6;  // effective address
            OP_CONST:       o_result = imm9;
            OP_JMP:         o_result = i_insn[11] ? pc_inc + imm11 : i_rs_data;
            OP_HICONST:     o_result = {i_insn[7:0], i_rs_data[7:0]};
            default:        o_result = '0;
        endcase
    end

endmodule

/* source/lc4_regfile.sv */
// eight-entry lc4 register file, two read ports and one write port with write-through
module lc4_regfile (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pkg::reg_sel_t i_rs_sel,
    input  lc4_pkg::reg_sel_t i_rt_sel,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data,
    input  lc4_pkg::reg_sel_t i_rd_sel,
    input  logic              i_rd_we,
    input  lc4_pkg::word_t    i_rd_data
);
    import lc4_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // a read of the register written this cycle sees the new value
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

    a_sel_known: assert property (@(posedge gwe) disable iff (i_rst)
        !$isunknown({i_rs_sel, i_rt_sel}))
        else $error("register read select unknown");

endmodule

/* source/lc4_hazard_unit.sv */
// lc4 load-to-use stall detection and bypass source selection for execute and memory
module lc4_hazard_unit (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pkg::reg_sel_t i_d_rs_sel,
    input  lc4_pkg::reg_sel_t i_d_rt_sel,
    input  logic              i_d_rs_re,
    input  logic              i_d_rt_re,
    input  logic              i_d_is_store,
    input  logic              i_d_is_branch,
    input  lc4_pkg::reg_sel_t i_x_rd_sel,
    input  logic              i_x_is_load,
    input  lc4_pkg::reg_sel_t i_x_rs_sel,
    input  lc4_pkg::reg_sel_t i_x_rt_sel,
    input  lc4_pkg::reg_sel_t i_m_rd_sel,
    input  logic              i_m_reg_we,
    input  lc4_pkg::reg_sel_t i_m_rt_sel,
    input  logic              i_m_is_store,
    input  lc4_pkg::reg_sel_t i_w_rd_sel,
    input  logic              i_w_reg_we,
    output logic              o_stall,
    output lc4_pkg::fwd_t     o_rs_fwd,
    output lc4_pkg::fwd_t     o_rt_fwd,
    output logic              o_store_fwd_w
);
    import lc4_pkg::*;

    logic rs_dep, rt_dep;

    assign rs_dep = i_d_rs_re && (i_d_rs_sel == i_x_rd_sel);
    assign rt_dep = i_d_rt_re && !i_d_is_store && (i_d_rt_sel == i_x_rd_sel);  // wm covers store data
    assign o_stall = i_x_is_load && (rs_dep || rt_dep || i_d_is_branch);  // branch waits for load nzp

    // the younger producer in m wins over w
    assign o_rs_fwd = (i_m_reg_we && i_m_rd_sel == i_x_rs_sel) ? FWD_M :
                      (i_w_reg_we && i_w_rd_sel == i_x_rs_sel) ? FWD_W : FWD_REG;
    assign o_rt_fwd = (i_m_reg_we && i_m_rd_sel == i_x_rt_sel) ? FWD_M :
                      (i_w_reg_we && i_w_rd_sel == i_x_rt_sel) ? FWD_W : FWD_REG;

    assign o_store_fwd_w = i_m_is_store && i_w_reg_we && (i_w_rd_sel == i_m_rt_sel);

    // the bubble put into x clears the load, so a stall never repeats
    a_stall_once: assert property (@(posedge gwe) disable iff (i_rst) o_stall |=> !o_stall)
        else $error("stall held for two cycles");

endmodule

/* source/lc4_fetch.sv */
// lc4 fetch stage: pc register, next pc choice and the decode instruction register
module lc4_fetch (
    input  logic           gwe,
    input  logic           i_rst,
    input  logic           i_stall,
    input  logic           i_redirect,
    input  lc4_pkg::word_t i_redirect_pc,
    input  lc4_pkg::word_t i_imem_insn,
    output lc4_pkg::word_t o_imem_addr,
    output lc4_pkg::word_t o_d_insn,
    output lc4_pkg::word_t o_d_pc,
    output logic           o_d_valid
);
    import lc4_pkg::*;

    word_t pc;

    assign o_imem_addr = pc;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc        <= PC_RESET;
            o_d_insn  <= '0;
            o_d_valid <= 1'b0;
        end else if (i_redirect) begin  // flush wins over stall
            pc        <= i_redirect_pc;
            o_d_insn  <= '0;             // br with nzp 000, a no-op
            o_d_valid <= 1'b0;
        end else if (!i_stall) begin
            pc        <= pc + 16'd1;
            o_d_insn  <= i_imem_insn;
            o_d_valid <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (!i_stall) begin
            o_d_pc <= pc;
        end
    end

endmodule

/* source/lc4_execute.sv */
// lc4 execute stage: x register, operand bypass, alu, nzp register and redirect decision
module lc4_execute (
    input  logic              gwe,
    input  logic              i_rst,
    input  logic              i_stall,
    input  lc4_pkg::word_t    i_d_insn,
    input  lc4_pkg::word_t    i_d_pc,
    input  logic              i_d_valid,
    input  lc4_pkg::reg_sel_t i_d_rs_sel,
    input  lc4_pkg::reg_sel_t i_d_rt_sel,
    input  lc4_pkg::reg_sel_t i_d_rd_sel,
    input  logic              i_d_reg_we,
    input  logic              i_d_nzp_we,
    input  logic              i_d_is_load,
    input  logic              i_d_is_store,
    input  logic              i_d_is_branch,
    input  logic              i_d_is_control,
    input  lc4_pkg::word_t    i_rs_data,
    input  lc4_pkg::word_t    i_rt_data,
    input  lc4_pkg::fwd_t     i_rs_fwd,
    input  lc4_pkg::fwd_t     i_rt_fwd,
    input  lc4_pkg::word_t    i_m_value,
    input  lc4_pkg::word_t    i_w_value,
    input  lc4_pkg::nzp_t     i_load_nzp,
    input  logic              i_load_nzp_we,
    output logic              o_redirect,
    output lc4_pkg::word_t    o_redirect_pc,
    output lc4_pkg::word_t    o_x_insn,
    output lc4_pkg::word_t    o_x_pc,
    output logic              o_x_valid,
    output lc4_pkg::reg_sel_t o_x_rd_sel,
    output lc4_pkg::reg_sel_t o_x_rs_sel,
    output lc4_pkg::reg_sel_t o_x_rt_sel,
    output logic              o_x_reg_we,
    output logic              o_x_is_load,
    output logic              o_x_is_store,
    output lc4_pkg::word_t    o_x_result,
    output lc4_pkg::word_t    o_x_rt_value
);
    import lc4_pkg::*;

    logic  x_nzp_we, x_is_branch, x_is_control;
    word_t x_rs_data, x_rt_data, rs_value;
    nzp_t  nzp;

    always_ff @(posedge gwe) begin
        if (i_rst || i_stall || o_redirect) begin  // bubble
            o_x_valid    <= 1'b0;
            o_x_reg_we   <= 1'b0;
            x_nzp_we     <= 1'b0;
            o_x_is_load  <= 1'b0;
            o_x_is_store <= 1'b0;
            x_is_branch  <= 1'b0;
            x_is_control <= 1'b0;
        end else begin
            o_x_valid    <= i_d_valid;
            o_x_reg_we   <= i_d_reg_we;
            x_nzp_we     <= i_d_nzp_we;
            o_x_is_load  <= i_d_is_load;
            o_x_is_store <= i_d_is_store;
            x_is_branch  <= i_d_is_branch;
            x_is_control <= i_d_is_control;
        end
    end

    always_ff @(posedge gwe) begin
        o_x_insn   <= i_d_insn;
        o_x_pc     <= i_d_pc;
        o_x_rd_sel <= i_d_rd_sel;
        o_x_rs_sel <= i_d_rs_sel;
        o_x_rt_sel <= i_d_rt_sel;
        x_rs_data  <= i_rs_data;
        x_rt_data  <= i_rt_data;
    end

    always_comb begin
        case (i_rs_fwd)
            FWD_M:   rs_value = i_m_value;
            FWD_W:   rs_value = i_w_value;
            default: rs_value = x_rs_data;
        endcase
        case (i_rt_fwd)
            FWD_M:   o_x_rt_value = i_m_value;
            FWD_W:   o_x_rt_value = i_w_value;
            default: o_x_rt_value = x_rt_data;
        endcase
    end

    lc4_alu i_lc4_alu (
        .i_insn(o_x_insn), .i_pc(o_x_pc),
        .i_rs_data(rs_value), .i_rt_data(o_x_rt_value),
        .o_result(o_x_result)
    );

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp <= '0;
        end else if (x_nzp_we && !o_x_is_load) begin
            nzp <= nzp_of(o_x_result);
        end else if (i_load_nzp_we) begin
            nzp <= i_load_nzp;                  // older load finishing in m
        end
    end

    assign o_redirect    = x_is_control || (x_is_branch && |(o_x_insn[11:9] & nzp));
    assign o_redirect_pc = o_x_result;

    // a redirect comes from a real instruction in x
    a_redirect_valid: assert property (@(posedge gwe) disable iff (i_rst)
        o_redirect |-> o_x_valid)
        else $error("redirect from a bubble in x");

endmodule

/* source/lc4_mem_wb.sv */
// lc4 memory and writeback stages: data memory port, store bypass, writeback value, retire trace
module lc4_mem_wb (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pkg::word_t    i_x_insn,
    input  lc4_pkg::word_t    i_x_pc,
    input  logic              i_x_valid,
    input  lc4_pkg::reg_sel_t i_x_rd_sel,
    input  logic              i_x_reg_we,
    input  logic              i_x_is_load,
    input  logic              i_x_is_store,
    input  lc4_pkg::reg_sel_t i_x_rt_sel,
    input  lc4_pkg::word_t    i_x_result,
    input  lc4_pkg::word_t    i_x_rt_value,
    input  logic              i_store_fwd_w,
    input  lc4_pkg::word_t    i_dmem_rdata,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_wdata,
    output lc4_pkg::reg_sel_t o_m_rd_sel,
    output lc4_pkg::reg_sel_t o_m_rt_sel,
    output logic              o_m_reg_we,
    output logic              o_m_is_store,
    output lc4_pkg::word_t    o_m_value,
    output lc4_pkg::word_t    o_w_value,
    output lc4_pkg::nzp_t     o_load_nzp,
    output logic              o_load_nzp_we,
    output lc4_pkg::reg_sel_t o_w_rd_sel,
    output logic              o_w_reg_we,
    output logic              o_retire_valid,
    output lc4_pkg::word_t    o_retire_pc,
    output lc4_pkg::word_t    o_retire_insn,
    output logic              o_retire_we,
    output lc4_pkg::reg_sel_t o_retire_wsel,
    output lc4_pkg::word_t    o_retire_data,
    output lc4_pkg::nzp_t     o_retire_nzp
);
    import lc4_pkg::*;

    logic  m_valid, m_is_load, w_is_load;
    word_t m_insn, m_pc, m_rt_value, w_result, w_rdata;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            m_valid        <= 1'b0;
            o_m_reg_we     <= 1'b0;
            m_is_load      <= 1'b0;
            o_m_is_store   <= 1'b0;
            o_retire_valid <= 1'b0;
            o_w_reg_we     <= 1'b0;
            w_is_load      <= 1'b0;
        end else begin
            m_valid        <= i_x_valid;
            o_m_reg_we     <= i_x_reg_we;
            m_is_load      <= i_x_is_load;
            o_m_is_store   <= i_x_is_store;
            o_retire_valid <= m_valid;
            o_w_reg_we     <= o_m_reg_we;
            w_is_load      <= m_is_load;
        end
    end

    always_ff @(posedge gwe) begin
        m_insn        <= i_x_insn;
        m_pc          <= i_x_pc;
        o_m_rd_sel    <= i_x_rd_sel;
        o_m_rt_sel    <= i_x_rt_sel;
        o_m_value     <= i_x_result;
        m_rt_value    <= i_x_rt_value;
        o_retire_insn <= m_insn;
        o_retire_pc   <= m_pc;
        o_w_rd_sel    <= o_m_rd_sel;
        w_result      <= o_m_value;
        w_rdata       <= i_dmem_rdata;
    end

    assign o_dmem_addr   = (m_is_load || o_m_is_store) ? o_m_value : '0;
    assign o_dmem_we     = o_m_is_store;
    assign o_dmem_wdata  = i_store_fwd_w ? o_w_value : m_rt_value;  // wm path
    assign o_load_nzp    = nzp_of(i_dmem_rdata);
    assign o_load_nzp_we = m_is_load;

    assign o_w_value     = w_is_load ? w_rdata : w_result;
    assign o_retire_we   = o_w_reg_we;
    assign o_retire_wsel = o_w_rd_sel;
    assign o_retire_data = o_w_value;
    assign o_retire_nzp  = nzp_of(o_w_value);

    a_no_store_on_load: assert property (@(posedge gwe) disable iff (i_rst)
        o_dmem_we |-> !m_is_load)
        else $error("data memory write with a load in m");

endmodule

/* source/lc4_processor.sv */
// lc4 five-stage pipelined processor top; connect instruction and data memories and the retire trace
module lc4_processor (
    input  logic              gwe,
    input  logic              i_rst,
    output lc4_pkg::word_t    o_imem_addr,
    input  lc4_pkg::word_t    i_imem_insn,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_wdata,
    input  lc4_pkg::word_t    i_dmem_rdata,
    output logic              o_retire_valid,
    output lc4_pkg::word_t    o_retire_pc,
    output lc4_pkg::word_t    o_retire_insn,
    output logic              o_retire_we,
    output lc4_pkg::reg_sel_t o_retire_wsel,
    output lc4_pkg::word_t    o_retire_data,
    output lc4_pkg::nzp_t     o_retire_nzp
);
    import lc4_pkg::*;

    logic     stall, redirect, store_fwd_w, load_nzp_we;
    word_t    redirect_pc, d_insn, d_pc, rs_data, rt_data;
    logic     d_valid, d_rs_re, d_rt_re, d_reg_we, d_nzp_we;
    logic     d_is_load, d_is_store, d_is_branch, d_is_control;
    reg_sel_t d_rs_sel, d_rt_sel, d_rd_sel;
    fwd_t     rs_fwd, rt_fwd;
    word_t    x_insn, x_pc, x_result, x_rt_value, m_value, w_value;
    logic     x_valid, x_reg_we, x_is_load, x_is_store;
    reg_sel_t x_rd_sel, x_rs_sel, x_rt_sel, m_rd_sel, m_rt_sel, w_rd_sel;
    logic     m_reg_we, m_is_store, w_reg_we;
    nzp_t     load_nzp;

    lc4_fetch i_lc4_fetch (
        .gwe(gwe), .i_rst(i_rst), .i_stall(stall),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc), .i_imem_insn(i_imem_insn),
        .o_imem_addr(o_imem_addr), .o_d_insn(d_insn), .o_d_pc(d_pc), .o_d_valid(d_valid)
    );

    lc4_decoder i_lc4_decoder (
        .i_insn(d_insn), .o_rs_sel(d_rs_sel), .o_rt_sel(d_rt_sel), .o_rd_sel(d_rd_sel),
        .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_reg_we(d_reg_we), .o_nzp_we(d_nzp_we),
        .o_is_load(d_is_load), .o_is_store(d_is_store),
        .o_is_branch(d_is_branch), .o_is_control(d_is_control)
    );

    lc4_regfile i_lc4_regfile (
        .gwe(gwe), .i_rst(i_rst), .i_rs_sel(d_rs_sel), .i_rt_sel(d_rt_sel),
        .o_rs_data(rs_data), .o_rt_data(rt_data),
        .i_rd_sel(w_rd_sel), .i_rd_we(w_reg_we), .i_rd_data(w_value)
    );

    lc4_hazard_unit i_lc4_hazard_unit (
        .gwe(gwe), .i_rst(i_rst),
        .i_d_rs_sel(d_rs_sel), .i_d_rt_sel(d_rt_sel), .i_d_rs_re(d_rs_re), .i_d_rt_re(d_rt_re),
        .i_d_is_store(d_is_store), .i_d_is_branch(d_is_branch),
        .i_x_rd_sel(x_rd_sel), .i_x_is_load(x_is_load),
        .i_x_rs_sel(x_rs_sel), .i_x_rt_sel(x_rt_sel),
        .i_m_rd_sel(m_rd_sel), .i_m_reg_we(m_reg_we),
        .i_m_rt_sel(m_rt_sel), .i_m_is_store(m_is_store),
        .i_w_rd_sel(w_rd_sel), .i_w_reg_we(w_reg_we),
        .o_stall(stall), .o_rs_fwd(rs_fwd), .o_rt_fwd(rt_fwd), .o_store_fwd_w(store_fwd_w)
    );

    lc4_execute i_lc4_execute (
        .gwe(gwe), .i_rst(i_rst), .i_stall(stall),
        .i_d_insn(d_insn), .i_d_pc(d_pc), .i_d_valid(d_valid),
        .i_d_rs_sel(d_rs_sel), .i_d_rt_sel(d_rt_sel), .i_d_rd_sel(d_rd_sel),
        .i_d_reg_we(d_reg_we), .i_d_nzp_we(d_nzp_we), .i_d_is_load(d_is_load),
        .i_d_is_store(d_is_store), .i_d_is_branch(d_is_branch), .i_d_is_control(d_is_control),
        .i_rs_data(rs_data), .i_rt_data(rt_data), .i_rs_fwd(rs_fwd), .i_rt_fwd(rt_fwd),
        .i_m_value(m_value), .i_w_value(w_value),
        .i_load_nzp(load_nzp), .i_load_nzp_we(load_nzp_we),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_x_insn(x_insn), .o_x_pc(x_pc), .o_x_valid(x_valid),
        .o_x_rd_sel(x_rd_sel), .o_x_rs_sel(x_rs_sel), .o_x_rt_sel(x_rt_sel),
        .o_x_reg_we(x_reg_we), .o_x_is_load(x_is_load), .o_x_is_store(x_is_store),
        .o_x_result(x_result), .o_x_rt_value(x_rt_value)
    );

    lc4_mem_wb i_lc4_mem_wb (
        .gwe(gwe), .i_rst(i_rst),
        .i_x_insn(x_insn), .i_x_pc(x_pc), .i_x_valid(x_valid),
        .i_x_rd_sel(x_rd_sel), .i_x_reg_we(x_reg_we),
        .i_x_is_load(x_is_load), .i_x_is_store(x_is_store), .i_x_rt_sel(x_rt_sel),
        .i_x_result(x_result), .i_x_rt_value(x_rt_value),
        .i_store_fwd_w(store_fwd_w), .i_dmem_rdata(i_dmem_rdata),
        .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
        .o_m_rd_sel(m_rd_sel), .o_m_rt_sel(m_rt_sel),
        .o_m_reg_we(m_reg_we), .o_m_is_store(m_is_store),
        .o_m_value(m_value), .o_w_value(w_value),
        .o_load_nzp(load_nzp), .o_load_nzp_we(load_nzp_we),
        .o_w_rd_sel(w_rd_sel), .o_w_reg_we(w_reg_we),
        .o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
        .o_retire_insn(o_retire_insn), .o_retire_we(o_retire_we),
        .o_retire_wsel(o_retire_wsel), .o_retire_data(o_retire_data),
        .o_retire_nzp(o_retire_nzp)
    );

endmodule

/* verification/lc4_processor_tb.sv */
// testbench for lc4_processor; runs a fixed program and checks every retirement against a table
module lc4_processor_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import lc4_pkg::*;

    localparam int TABLE_LEN    = 26;   // retiring instructions in the program
    localparam int IMEM_DEPTH   = 64;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + 20 * TABLE_LEN + 50) * 10;

    logic     gwe;
    logic     i_rst;
    word_t    o_imem_addr, i_imem_insn, o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
    logic     o_dmem_we, o_retire_valid, o_retire_we;
    word_t    o_retire_pc, o_retire_insn, o_retire_data;
    reg_sel_t o_retire_wsel;
    nzp_t     o_retire_nzp;

    word_t    imem [IMEM_DEPTH];
    word_t    dmem [65536];
    word_t    init_mem [65536];  // untouched copy for expected values
    word_t    exp_pc [TABLE_LEN];
    word_t    exp_insn [TABLE_LEN];
    logic     exp_we [TABLE_LEN];
    reg_sel_t exp_wsel [TABLE_LEN];
    word_t    exp_data [TABLE_LEN];
    int       n_prog, n_exp, retired, stores_seen;
    word_t    store_addr, store_data, imem_off;

    lc4_processor i_lc4_processor (
        .gwe(gwe), .i_rst(i_rst),
        .o_imem_addr(o_imem_addr), .i_imem_insn(i_imem_insn),
        .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we),
        .o_dmem_wdata(o_dmem_wdata), .i_dmem_rdata(i_dmem_rdata),
        .o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
        .o_retire_insn(o_retire_insn), .o_retire_we(o_retire_we),
        .o_retire_wsel(o_retire_wsel), .o_retire_data(o_retire_data),
        .o_retire_nzp(o_retire_nzp)
    );

    always #5 gwe = ~gwe;

    // memories answer within the cycle
    assign imem_off     = o_imem_addr - PC_RESET;
    assign i_imem_insn  = (imem_off < IMEM_DEPTH) ? imem[imem_off[5:0]] : '0;  // no-op past end
    assign i_dmem_rdata = dmem[o_dmem_addr];

    always @(posedge gwe) begin
        if (o_dmem_we) begin
            dmem[o_dmem_addr] <= o_dmem_wdata;
        end
    end

    function automatic word_t xorshift(input word_t x);
        word_t s;
        s = x ^ (x << 7);
        s = s ^ (s >> 9);
        return s ^ (s << 8);
    endfunction

    function automatic nzp_t nzp_from_value(input word_t v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    // instruction encoders
    function automatic word_t enc_rr(opcode_t op, reg_sel_t d, reg_sel_t s, logic [2:0] sub,
                                     reg_sel_t t);
        return {op, d, s, sub, t};
    endfunction

    function automatic word_t enc_ri(opcode_t op, reg_sel_t d, reg_sel_t s, logic [4:0] imm);
        return {op, d, s, 1'b1, imm};
    endfunction

    function automatic word_t enc_mem(opcode_t op, reg_sel_t d, reg_sel_t s, logic [5:0] off);
        return {op, d, s, off};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            fail_run("retire or memory value wrong");
        end
    endtask

    task automatic check_sel(input string name, input reg_sel_t got, input reg_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            fail_run("register select wrong");
        end
    endtask

    task automatic check_nzp(input string name, input nzp_t got, input nzp_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            fail_run("condition bits wrong");
        end
    endtask

    // place one instruction; a retiring one also gets a row in the expected table
    task automatic emit(input word_t insn, input logic retires, input logic we,
                        input reg_sel_t wsel, input word_t data);
        if (retires) begin
            exp_pc[n_exp]   = PC_RESET + 16'(n_prog);
            exp_insn[n_exp] = insn;
            exp_we[n_exp]   = we;
            exp_wsel[n_exp] = wsel;
            exp_data[n_exp] = data;
            n_exp++;
        end
        imem[n_prog] = insn;
        n_prog++;
    endtask

    task automatic build_program();
        word_t ld, st, flip;
        ld = init_mem[16'h0042];
        st = ld + 16'd8;
        flip = (st == 16'h0000) ? 16'h0001 : 16'h0000;  // nzp other than the reloaded value
        store_addr = 16'h0045;
        store_data = st;
        // dependent alu chain over mx and wx
        emit({OP_CONST, 3'd1, 9'd5}, 1, 1, 1, 16'h0005);
        emit({OP_HICONST, 3'd1, 1'b1, 8'h12}, 1, 1, 1, 16'h1205);
        emit({OP_CONST, 3'd2, 9'h1FD}, 1, 1, 2, 16'hFFFD);
        emit(enc_rr(OP_ARITH, 3, 1, 3'b000, 2), 1, 1, 3, 16'h1202);
        emit(enc_rr(OP_ARITH, 4, 3, 3'b010, 1), 1, 1, 4, 16'hFFFD);
        emit(enc_rr(OP_LOGIC, 5, 3, 3'b000, 4), 1, 1, 5, 16'h1200);
        emit(enc_rr(OP_LOGIC, 6, 5, 3'b010, 2), 1, 1, 6, 16'hFFFD);
        emit(enc_rr(OP_LOGIC, 7, 6, 3'b011, 1), 1, 1, 7, 16'hEDF8);
        emit(enc_rr(OP_LOGIC, 7, 7, 3'b001, 0), 1, 1, 7, 16'h1207);
        emit(enc_ri(OP_ARITH, 1, 1, 5'h1F), 1, 1, 1, 16'h1204);
        emit(enc_ri(OP_LOGIC, 2, 7, 5'h07), 1, 1, 2, 16'h0007);
        // load to use, then store with bypassed data and a reload
        emit({OP_CONST, 3'd3, 9'h040}, 1, 1, 3, 16'h0040);
        emit(enc_mem(OP_LDR, 4, 3, 6'd2), 1, 1, 4, ld);
        emit(enc_rr(OP_ARITH, 5, 4, 3'b000, 2), 1, 1, 5, ld + 16'd7);
        emit(enc_ri(OP_ARITH, 6, 5, 5'd1), 1, 1, 6, st);
        emit(enc_mem(OP_STR, 6, 3, 6'd5), 1, 0, 0, 16'h0000);
        emit({OP_CONST, 3'd1, flip[8:0]}, 1, 1, 1, flip);
        emit(enc_mem(OP_LDR, 7, 3, 6'd5), 1, 1, 7, st);
        // branch right after a load on the bits the load did not set
        emit({OP_BR, ~nzp_from_value(st), 9'd3}, 1, 0, 0, 16'h0000);
        emit({OP_CONST, 3'd1, 9'd0}, 1, 1, 1, 16'h0000);
        emit({OP_BR, 3'b010, 9'd2}, 1, 0, 0, 16'h0000);  // taken to 8217
        emit({OP_CONST, 3'd2, 9'd1}, 0, 0, 0, 16'h0000);
        emit({OP_CONST, 3'd2, 9'd2}, 0, 0, 0, 16'h0000);
        emit({OP_JMP, 1'b1, 11'd2}, 1, 0, 0, 16'h0000);   // to 821a
        emit({OP_CONST, 3'd0, 9'd1}, 0, 0, 0, 16'h0000);
        emit({OP_CONST, 3'd0, 9'd1}, 0, 0, 0, 16'h0000);
        emit({OP_CONST, 3'd6, 9'h020}, 1, 1, 6, 16'h0020);
        emit({OP_HICONST, 3'd6, 1'b1, 8'h82}, 1, 1, 6, 16'h8220);
        emit({OP_JMP, 3'b000, 3'd6, 6'd0}, 1, 0, 0, 16'h0000);  // jmpr to 8220
        emit({OP_CONST, 3'd0, 9'd1}, 0, 0, 0, 16'h0000);
        emit({OP_CONST, 3'd0, 9'd1}, 0, 0, 0, 16'h0000);
        emit({OP_CONST, 3'd0, 9'd1}, 0, 0, 0, 16'h0000);
        emit(enc_rr(OP_ARITH, 0, 6, 3'b000, 2), 1, 1, 0, 16'h8227);
    endtask

    initial begin
        word_t state;
        gwe         = 1'b0;
        i_rst       = 1'b1;
        n_prog      = 0;
        n_exp       = 0;
        retired     = 0;
        stores_seen = 0;
        state       = 16'd20021;
        for (int a = 0; a < 65536; a++) begin
            state       = xorshift(state);
            init_mem[a] = state ^ 16'(a);
            dmem[a]     = init_mem[a];
        end
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = '0;
        end
        build_program();
        if (n_exp != TABLE_LEN) fail_run("expected table length does not match the program");
        repeat (RESET_CYCLES) @(posedge gwe);
        i_rst <= 1'b0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            do @(negedge gwe); while (!o_retire_valid);
            check_word("o_retire_pc", o_retire_pc, exp_pc[i]);
            check_word("o_retire_insn", o_retire_insn, exp_insn[i]);
            check_word("o_retire_we", 16'(o_retire_we), 16'(exp_we[i]));
            if (exp_we[i]) begin
                check_sel("o_retire_wsel", o_retire_wsel, exp_wsel[i]);
                check_word("o_retire_data", o_retire_data, exp_data[i]);
                check_nzp("o_retire_nzp", o_retire_nzp, nzp_from_value(exp_data[i]));
            end
            retired++;
        end
        if (stores_seen != 1) fail_run("the store never reached data memory");
        $display("sim passed");
        $finish;
    end

    // data memory writes and the quiet period after reset
    always @(negedge gwe) begin
        if (i_rst && o_retire_valid) fail_run("retire valid high during reset");
        if (o_dmem_we) begin
            if (i_rst || retired == 0) fail_run("data memory written before any retirement");
            if (stores_seen != 0) fail_run("more than one data memory write");
            check_word("o_dmem_addr", o_dmem_addr, store_addr);
            check_word("o_dmem_wdata", o_dmem_wdata, store_data);
            stores_seen++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("processor did not retire the program in time");
    end

endmodule

/* build.f */
source/lc4_pkg.sv
source/lc4_decoder.sv
source/lc4_alu.sv
source/lc4_regfile.sv
source/lc4_hazard_unit.sv
source/lc4_fetch.sv
source/lc4_execute.sv
source/lc4_mem_wb.sv
source/lc4_processor.sv
verification/lc4_processor_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run; pass only if the log holds the pass line
verilator --binary --timing --assert --top-module lc4_processor_tb -f build.f -o sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
